//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_color_vision
RTL_TOP   := color_vision_top
FILELIST  := color_vision.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "simulation PASSED" || (echo "simulation FAILED"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- color_vision.f
logic/vision_pkg.sv
logic/ycbcr_decoder.sv
logic/rgb_to_hsv.sv
logic/color_classifier.sv
logic/class_frame_buffer.sv
logic/color_vision_top.sv
testbench/clock_gen.sv
testbench/tb_color_vision.sv

//--- logic/class_frame_buffer.sv
`timescale 1ns/1ps
// Class frame buffer
// stores one 180x120 frame of class flags that the host reads over req/ack
module class_frame_buffer
	import vision_pkg::*;
(
	input  logic      clk_llc,
	input  logic      resetx,
	input  logic      frame_start,
	input  class_t    flags,
	input  logic      class_valid,
	input  logic      rd_req,
	input  pix_addr_t rd_addr,
	output logic      rd_ack,
	output class_t    rd_data
);
	typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_ACK, RD_RELEASE} rd_state_e;

	class_t mem [FRAME_PIXELS];
	pix_addr_t wr_addr;
	class_t rd_word;  // second port output
	rd_state_e rd_state;

	// ------------------------------------------------------------------
	// write side in stream order
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			wr_addr <= '0;
		else if (frame_start)
			wr_addr <= '0;
		else if (class_valid)
			wr_addr <= (wr_addr == pix_addr_t'(FRAME_PIXELS - 1)) ? '0 : wr_addr + 1'b1;
	end

	always_ff @(posedge clk_llc)
	begin
		if (class_valid)
			mem[wr_addr] <= flags;
		rd_word <= mem[rd_addr];
	end

	// ------------------------------------------------------------------
	// four phase read FSM
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			rd_state <= RD_IDLE;
			rd_ack <= 1'b0;
		end
		else
		begin
			case (rd_state)
				RD_IDLE: if (rd_req) rd_state <= RD_FETCH;
				RD_FETCH:
				begin
					rd_ack <= 1'b1;  // rd_word now holds mem[rd_addr]
					rd_state <= RD_ACK;
				end
				RD_ACK:
				begin
					if (!rd_req)
					begin
						rd_ack <= 1'b0;
						rd_state <= RD_RELEASE;
					end
				end
				default: rd_state <= rd_req ? RD_FETCH : RD_IDLE;  // back to back ok
			endcase
		end
	end

	// held until the host drops rd_req
	always_ff @(posedge clk_llc)
	begin
		if (rd_state == RD_FETCH)
			rd_data <= rd_word;
	end

	a_rd_addr_range: assert property (@(posedge clk_llc) disable iff (!resetx)
		rd_req |-> rd_addr < FRAME_PIXELS);

	// ack only answers a pending request
	a_ack_needs_req: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(rd_ack) |-> $past(rd_req));

endmodule

//--- logic/color_classifier.sv
`timescale 1ns/1ps
// Colour classifier
// HSV thresholds into red, orange, yellow, green, blue and black flags
module color_classifier
	import vision_pkg::*;
(
	input  logic   clk_llc,
	input  logic   resetx,
	input  hsv_t   hsv,
	input  logic   hsv_valid,
	output class_t flags,
	output logic   class_valid
);
	logic black_c;
	logic black_q, hi_q, lo_q;  // stage one conditions
	byte_t h_q;
	logic s1_valid;

	// window centre +- tolerance, no wrap at 240
	function automatic logic in_window(input byte_t h, input int centre);
		return (int'(h) >= centre - HUE_TOL) && (int'(h) <= centre + HUE_TOL);
	endfunction

	assign black_c = (hsv.s < SAT_HIGH) && (hsv.v < VAL_DARK);  // dark, weak colour

	// stage one, saturation classes
	always_ff @(posedge clk_llc)
	begin
		black_q <= black_c;
		hi_q    <= !black_c && (hsv.s > SAT_HIGH);
		lo_q    <= !black_c && (hsv.s > SAT_LOW);
		h_q     <= hsv.h;
	end

	// stage two, hue windows
	always_ff @(posedge clk_llc)
	begin
		flags.red    <= lo_q & in_window(h_q, HUE_RED);
		flags.orange <= lo_q & in_window(h_q, HUE_ORANGE);
		flags.yellow <= lo_q & in_window(h_q, HUE_YELLOW);
		flags.green  <= lo_q & in_window(h_q, HUE_GREEN);
		flags.blue   <= hi_q & in_window(h_q, HUE_BLUE);  // blue needs strong sat
		flags.black  <= black_q;
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_valid    <= 1'b0;
			class_valid <= 1'b0;
		end
		else
		begin
			s1_valid    <= hsv_valid;
			class_valid <= s1_valid;
		end
	end

endmodule

//--- logic/color_vision_top.sv
`timescale 1ns/1ps
// Colour vision top level
// decoder, HSV converter, classifier and class buffer on clk_llc
module color_vision_top (
	input  logic        clk_llc,
	input  logic        resetx,
	input  logic        video_valid,
	input  logic [7:0]  video_byte,  // Cb Y0 Cr Y1 order
	input  logic        frame_start,
	input  logic        rd_req,
	input  logic [14:0] rd_addr,
	output logic        rd_ack,
	output logic [5:0]  rd_data
);
	logic [23:0] rgb;    // r g b
	logic        rgb_valid;
	logic [23:0] hsv;    // h s v
	logic        hsv_valid;
	logic [5:0]  flags;
	logic        class_valid;

	ycbcr_decoder u_decoder (
		.clk_llc(clk_llc), .resetx(resetx),
		.video_valid(video_valid), .video_byte(video_byte),
		.rgb(rgb), .rgb_valid(rgb_valid)
	);

	rgb_to_hsv u_hsv (
		.clk_llc(clk_llc), .resetx(resetx),
		.rgb(rgb), .rgb_valid(rgb_valid),
		.hsv(hsv), .hsv_valid(hsv_valid)
	);

	color_classifier u_classifier (
		.clk_llc(clk_llc), .resetx(resetx),
		.hsv(hsv), .hsv_valid(hsv_valid),
		.flags(flags), .class_valid(class_valid)
	);

	class_frame_buffer u_buffer (
		.clk_llc(clk_llc), .resetx(resetx), .frame_start(frame_start),
		.flags(flags), .class_valid(class_valid),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data)
	);

endmodule

//--- logic/rgb_to_hsv.sv
`timescale 1ns/1ps
// RGB888 to HSV converter
// three stage pipeline, hue on a 0..239 scale, s and v on 0..255
module rgb_to_hsv
	import vision_pkg::*;
(
	input  logic  clk_llc,
	input  logic  resetx,
	input  rgb_t  rgb,
	input  logic  rgb_valid,
	output hsv_t  hsv,
	output logic  hsv_valid
);
	typedef enum logic [1:0] {MAX_R, MAX_G, MAX_B} max_ch_e;

	byte_t c_max, c_min;
	max_ch_e ch;
	logic signed [8:0] diff;  // hue difference, -255..255

	byte_t s1_max, s1_min;
	max_ch_e s1_ch;
	logic signed [8:0] s1_diff;
	byte_t s2_max, s2_delta;
	max_ch_e s2_ch;
	logic signed [8:0] s2_diff;
	logic s1_valid, s2_valid;

	int den, hue_q, hue, sat;

	// ------------------------------------------------------------------
	// stage one, max / min and which channel wins
	always_comb
	begin
		if (rgb.r >= rgb.g && rgb.r >= rgb.b)
		begin
			ch = MAX_R;  // red wins ties
			c_max = rgb.r;
			diff = $signed({1'b0, rgb.g}) - $signed({1'b0, rgb.b});
		end
		else if (rgb.g >= rgb.b)
		begin
			ch = MAX_G;
			c_max = rgb.g;
			diff = $signed({1'b0, rgb.b}) - $signed({1'b0, rgb.r});
		end
		else
		begin
			ch = MAX_B;
			c_max = rgb.b;
			diff = $signed({1'b0, rgb.r}) - $signed({1'b0, rgb.g});
		end
		c_min = (rgb.r <= rgb.g) ? rgb.r : rgb.g;
		if (rgb.b < c_min)
			c_min = rgb.b;
	end

	always_ff @(posedge clk_llc)
	begin
		s1_max   <= c_max;
		s1_min   <= c_min;
		s1_ch    <= ch;
		s1_diff  <= diff;
		s2_max   <= s1_max;  // stage two, delta
		s2_delta <= s1_max - s1_min;
		s2_ch    <= s1_ch;
		s2_diff  <= s1_diff;
	end

	// ------------------------------------------------------------------
	// stage three, hue and saturation divides
	always_comb
	begin
		den = (s2_delta == 8'd0) ? 1 : int'(s2_delta);  // keep divider defined
		hue_q = (int'(s2_diff) * HUE_SECTOR) / den;
		case (s2_ch)
			MAX_R: hue = (hue_q + HUE_FULL) % HUE_FULL;
			MAX_G: hue = hue_q + 2 * HUE_SECTOR;   // +80
			default: hue = hue_q + 4 * HUE_SECTOR; // +160
		endcase
		if (s2_delta == 8'd0)
			hue = 0;  // grey has no hue
		sat = (s2_max == 8'd0) ? 0 : (int'(s2_delta) * 255) / int'(s2_max);
	end

	always_ff @(posedge clk_llc)
	begin
		hsv.h <= hue[7:0];
		hsv.s <= sat[7:0];
		hsv.v <= s2_max;
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			hsv_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= rgb_valid;
			s2_valid  <= s1_valid;
			hsv_valid <= s2_valid;
		end
	end

endmodule

//--- logic/vision_pkg.sv
// Colour vision shared definitions
// pixel types, frame geometry, YCbCr coefficients and class thresholds
package vision_pkg;

	typedef logic [7:0]  byte_t;      // video sample or colour channel
	typedef logic [14:0] pix_addr_t;  // class buffer address

	typedef struct packed {
		byte_t r;
		byte_t g;
		byte_t b;
	} rgb_t;

	typedef struct packed {
		byte_t h;  // 0..239
		byte_t s;
		byte_t v;
	} hsv_t;

	// flag order from the msb
	typedef struct packed {
		logic red;
		logic orange;
		logic yellow;
		logic green;
		logic blue;
		logic black;
	} class_t;

	// ------------------------------------------------------------------
	// frame geometry, 180x120 decimated picture
	localparam int FRAME_W      = 180;
	localparam int FRAME_H      = 120;
	localparam int FRAME_PIXELS = FRAME_W * FRAME_H;  // 21600

	// ------------------------------------------------------------------
	// ycbcr to rgb, 2.8 fixed point
	localparam logic [9:0] K_Y    = 10'd298;  // 1.164
	localparam logic [9:0] K_CR_R = 10'd408;  // 1.596
	localparam logic [9:0] K_CR_G = 10'd208;  // 0.813
	localparam logic [9:0] K_CB_G = 10'd100;  // 0.392
	localparam logic [9:0] K_CB_B = 10'd516;  // 2.017

	// offsets on samples with two fraction bits
	localparam logic signed [10:0] Y_OFFSET = 11'sd64;
	localparam logic signed [10:0] C_OFFSET = 11'sd512;

	// ------------------------------------------------------------------
	// hue scale, six sectors of 40
	localparam int HUE_SECTOR = 40;
	localparam int HUE_FULL   = 240;

	// window centres
	localparam int HUE_RED    = 230;
	localparam int HUE_ORANGE = 10;
	localparam int HUE_YELLOW = 40;
	localparam int HUE_GREEN  = 85;
	localparam int HUE_BLUE   = 148;
	localparam int HUE_TOL    = 10;   // half width

	localparam byte_t SAT_HIGH = 8'd96;
	localparam byte_t SAT_LOW  = 8'd48;
	localparam byte_t VAL_DARK = 8'd96;

endpackage

//--- logic/ycbcr_decoder.sv
`timescale 1ns/1ps
// YCbCr 4:2:2 decoder
// takes Cb Y0 Cr Y1 byte quads and converts both pixels to saturated RGB888
module ycbcr_decoder
	import vision_pkg::*;
(
	input  logic  clk_llc,
	input  logic  resetx,
	input  logic  video_valid,
	input  byte_t video_byte,
	output rgb_t  rgb,
	output logic  rgb_valid
);
	typedef logic signed [20:0] fix_t;  // products and sums with 10 fraction bits
	typedef logic signed [10:0] off_t;  // offset sample with 2 fraction bits

	logic [1:0] phase;  // 0 Cb, 1 Y0, 2 Cr, 3 Y1
	byte_t cb_q, y0_q, cr_q;
	byte_t luma, cr_sel;
	off_t y_off, cb_off, cr_off;
	fix_t p_y, p_cr_r, p_cr_g, p_cb_g, p_cb_b;
	fix_t sum_r, sum_g, sum_b;
	logic s1_valid, s2_valid;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			phase <= 2'd0;
		else if (video_valid)
			phase <= phase + 2'd1;
		else
			phase <= 2'd0;  // next burst starts on Cb
	end

	// Cb Y0 Cr held per quad while Y1 is used straight off the bus
	always_ff @(posedge clk_llc)
	begin
		if (video_valid)
		begin
			case (phase)
				2'd0: cb_q <= video_byte;
				2'd1: y0_q <= video_byte;
				2'd2: cr_q <= video_byte;
				default: ;
			endcase
		end
	end

	// pixel 0 at Cr and pixel 1 at Y1 on the shared quad chroma
	always_comb
	begin
		if (phase == 2'd2)
		begin
			luma = y0_q;
			cr_sel = video_byte;
		end
		else
		begin
			luma = video_byte;
			cr_sel = cr_q;
		end
	end

	assign y_off  = $signed({1'b0, luma, 2'b00}) - Y_OFFSET;
	assign cb_off = $signed({1'b0, cb_q, 2'b00}) - C_OFFSET;
	assign cr_off = $signed({1'b0, cr_sel, 2'b00}) - C_OFFSET;

	// ------------------------------------------------------------------
	// stage one products and stage two sums
	always_ff @(posedge clk_llc)
	begin
		p_y    <= $signed({1'b0, K_Y}) * y_off;
		p_cr_r <= $signed({1'b0, K_CR_R}) * cr_off;
		p_cr_g <= $signed({1'b0, K_CR_G}) * cr_off;
		p_cb_g <= $signed({1'b0, K_CB_G}) * cb_off;
		p_cb_b <= $signed({1'b0, K_CB_B}) * cb_off;
		sum_r  <= p_y + p_cr_r;
		sum_g  <= p_y - p_cr_g - p_cb_g;
		sum_b  <= p_y + p_cb_b;
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= video_valid & phase[1];  // Cr or Y1 byte
			s2_valid <= s1_valid;
		end
	end

	// clamp to 0..255
	function automatic byte_t sat8(input fix_t v);
		if (v[20])
			return 8'd0;
		else if (v[19:18] != 2'b00)
			return 8'hff;
		else
			return v[17:10];
	endfunction

	assign rgb.r = sat8(sum_r);
	assign rgb.g = sat8(sum_g);
	assign rgb.b = sat8(sum_b);
	assign rgb_valid = s2_valid;

	// bursts end on whole quads so the phase rests at Cb between them
	a_phase_idle: assert property (@(posedge clk_llc) disable iff (!resetx)
		!video_valid |-> phase == 2'd0);

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ps
// Testbench clock and reset
// 8 ns clk_llc, resetx held low for the first 8 rising edges
module clock_gen (
	output logic clk_llc,
	output logic resetx
);
	initial
	begin
		clk_llc = 1'b0;
		forever #4 clk_llc = ~clk_llc;  // 125 MHz
	end

	initial
	begin
		resetx = 1'b0;
		repeat (8) @(posedge clk_llc);
		#1 resetx = 1'b1;  // release off the edge
	end

endmodule

//--- testbench/color_vision_vectors.txt
# frame cb y0 cr y1 exp0 exp1, all hex
# exp is class_t {red orange yellow green blue black}, pixel 0 then pixel 1
# bright grey, luma 200
01 80 c8 80 c8 00 00
# dark grey, luma 40 and 60
01 80 28 80 3c 01 01
# black then near white grey
01 80 10 80 eb 01 00
# red, rgb 244 18 121, hue 222
01 8c 64 dc 64 20 20
# orange, rgb 219 85 44, hue 9
01 5a 78 be 78 10 10
# yellow, rgb 191 164 18, hue 33
01 3c 96 96 96 08 08
# green, rgb 56 182 76, hue 86
01 64 82 50 82 04 04
# blue, rgb 41 80 231, hue 152
01 c8 5a 64 5a 02 02
# weak blue, rgb 143 153 200, sat 72
01 96 96 78 96 00 00
# weak green, rgb 127 175 129, sat 69
01 73 96 6e 96 04 04
# second frame, two quads from address 0
02 64 82 50 82 04 04
02 3c 96 96 96 08 08

//--- testbench/tb_color_vision.sv
`timescale 1ns/1ps
// Colour vision testbench
// streams YCbCr quads from the vector file, reads the class buffer back
// over the four-phase port and compares every pixel's flags
module tb_color_vision
	import vision_pkg::*;
();
	// one line of the vector file
	typedef struct packed {
		byte_t  frame;
		byte_t  cb;
		byte_t  y0;
		byte_t  cr;
		byte_t  y1;
		class_t exp0;
		class_t exp1;
	} vector_t;

	logic      clk_llc;
	logic      resetx;
	logic      video_valid;
	byte_t     video_byte;
	logic      frame_start;
	logic      rd_req;
	pix_addr_t rd_addr;
	logic      rd_ack;
	class_t    rd_data;

	vector_t vectors [$];
	class_t  model_mem [64];  // expected buffer contents in stream order
	int      model_addr;
	int      frame1_pixels;

	clock_gen u_clock (
		.clk_llc(clk_llc),
		.resetx(resetx)
	);

	color_vision_top UUT (
		.clk_llc(clk_llc), .resetx(resetx),
		.video_valid(video_valid), .video_byte(video_byte), .frame_start(frame_start),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data)
	);

	// ------------------------------------------------------------------
	// checks and waits
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual)
		else
		begin
			$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// four-phase wait on rd_ack sampled 1 ns after the edge
	task automatic wait_ack(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (rd_ack !== level && cycles < 20)
		begin
			@(posedge clk_llc);
			#1;
			cycles++;
		end
		if (rd_ack !== level)
		begin
			$display("timeout waiting for %s", what);
			$display("Test failures found");
			$fatal(1, "handshake timeout");
		end
	endtask

	// pipeline is quiet once class_valid stays low past the 8 cycle latency
	task automatic drain_pipeline();
		int idle;
		int cycles;
		idle = 0;
		cycles = 0;
		while (idle < 12 && cycles < 100)
		begin
			@(posedge clk_llc);
			#1;
			cycles++;
			if (UUT.u_buffer.class_valid)
				idle = 0;
			else
				idle++;
		end
		if (idle < 12)
		begin
			$display("pixel pipeline never went idle");
			$display("Test failures found");
			$fatal(1, "drain timeout");
		end
	endtask

	// ------------------------------------------------------------------
	// stimulus
	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic [31:0] f, cb, y0, cr, y1, e0, e1;
		fd = $fopen("testbench/color_vision_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open testbench/color_vision_vectors.txt");
			$display("Test failures found");
			$fatal(1, "no vector file");
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue;  // column notes
			n = $sscanf(line, "%h %h %h %h %h %h %h", f, cb, y0, cr, y1, e0, e1);
			if (n == 7)
				vectors.push_back({f[7:0], cb[7:0], y0[7:0], cr[7:0], y1[7:0],
					e0[5:0], e1[5:0]});
		end
		$fclose(fd);
		if (vectors.size() == 0)
		begin
			$display("vector file holds no quads");
			$display("Test failures found");
			$fatal(1, "empty vector file");
		end
	endtask

	task automatic send_byte(input byte_t b);
		@(posedge clk_llc);
		#1;
		video_valid = 1'b1;
		video_byte = b;
	endtask

	// frame_start pulse followed by every quad of that frame back to back
	task automatic stream_frame(input int frame_no);
		@(posedge clk_llc);
		#1;
		frame_start = 1'b1;
		@(posedge clk_llc);
		#1;
		frame_start = 1'b0;
		model_addr = 0;  // buffer restarts at address 0
		foreach (vectors[i])
		begin
			if (vectors[i].frame == frame_no)
			begin
				send_byte(vectors[i].cb);
				send_byte(vectors[i].y0);
				send_byte(vectors[i].cr);
				send_byte(vectors[i].y1);
				model_mem[model_addr] = vectors[i].exp0;
				model_mem[model_addr + 1] = vectors[i].exp1;
				model_addr += 2;  // two pixels per quad
			end
		end
		@(posedge clk_llc);
		#1;
		video_valid = 1'b0;
	endtask

	// ------------------------------------------------------------------
	// host side of the req/ack port
	task automatic read_word(input pix_addr_t addr, output class_t data);
		@(posedge clk_llc);
		#1;
		rd_addr = addr;
		rd_req = 1'b1;
		wait_ack(1'b1, "rd_ack to rise");
		data = rd_data;
		rd_req = 1'b0;
		wait_ack(1'b0, "rd_ack to fall");
	endtask

	task automatic check_frame(input string tag, input int count);
		class_t got;
		for (int a = 0; a < count; a++)
		begin
			read_word(pix_addr_t'(a), got);
			check_value($sformatf("%s_addr%0d", tag, a), model_mem[a], got);
		end
	endtask

	// slow host keeps rd_req up while ack and data stay put
	task automatic hold_read(input pix_addr_t addr);
		@(posedge clk_llc);
		#1;
		rd_addr = addr;
		rd_req = 1'b1;
		wait_ack(1'b1, "rd_ack on a held request");
		check_value("hold_first_data", model_mem[addr], rd_data);
		repeat (20)
		begin
			@(posedge clk_llc);
			#1;
			check_value("hold_ack", 1, rd_ack);
			check_value("hold_data", model_mem[addr], rd_data);
		end
		rd_req = 1'b0;
		wait_ack(1'b0, "rd_ack to fall after release");
	endtask

	initial
	begin
		class_t got;
		int cycles;
		video_valid = 1'b0;
		video_byte = '0;
		frame_start = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		load_vectors();

		cycles = 0;
		while (resetx !== 1'b1 && cycles < 50)
		begin
			@(posedge clk_llc);
			cycles++;
		end
		if (resetx !== 1'b1)
		begin
			$display("resetx never released");
			$display("Test failures found");
			$fatal(1, "reset timeout");
		end
		@(posedge clk_llc);
		#1;
		check_value("ack_after_reset", 0, rd_ack);

		// first frame with grey, hue and weak saturation quads
		stream_frame(1);
		frame1_pixels = model_addr;
		drain_pipeline();
		read_word('0, got);
		check_value("first_read_addr0", 0, got);  // bright grey quad
		check_frame("frame1", frame1_pixels);

		// short second frame overwrites the front only
		stream_frame(2);
		drain_pipeline();
		check_frame("frame2", frame1_pixels);

		hold_read(pix_addr_t'(14));  // saturated blue pixel

		$display("All tests passed!");
		$finish;
	end

endmodule
